// ==== testbench/issue_patterns.txt ====
// columns, all hex: instruction word, expected rd, expected result value
// word layout: op[15:12] rd[11:9] rs1[8:6] then rs2[5:3] or imm[5:0]
4205 1 0005 // addi r1, r0, 5
443D 2 FFFD // addi r2, r0, -3
5621 3 8400 // lui r3, 0x21
0850 4 0002 // add r4, r1, r2
1A58 5 7C05 // sub r5, r1, r3
2C98 6 8400 // and r6, r2, r3
3E88 7 FFF8 // xor r7, r2, r1
4247 1 000C // addi r1, r1, 7
4247 1 0013 // addi r1, r1, 7
0248 1 0026 // add r1, r1, r1
1260 1 0024 // sub r1, r1, r4
5A01 5 0400 // lui r5, 1
0448 2 0048 // add r2, r1, r1
2690 3 0048 // and r3, r2, r2
3888 4 006C // xor r4, r2, r1
1C88 6 0024 // sub r6, r2, r1
4EB8 7 0040 // addi r7, r2, -8
3A00 5 0000 // xor r5, r0, r0
563F 3 FC00 // lui r3, 0x3f
08F8 4 FC40 // add r4, r3, r7

// ==== verilog.f ====
+incdir+include
src/decode_pkg.sv
src/issue_pkg.sv
src/dispatch_unit.sv
src/issue_queue.sv
src/exec_unit.sv
src/ooo_issue_top.sv
testbench/issue_properties.sv
testbench/issue_tb.sv

// ==== testbench/issue_tb.sv ====
`timescale 1ns/1ns

module issue_tb
	import decode_pkg::*;
();
	localparam int MAX_PAT = 32;
	localparam int PASSES = 2;
	localparam int TIMEOUT = 400;

	logic clk;
	logic reset;
	logic in_valid;
	instr_u in_instr;
	logic full;
	logic result_valid;
	logic [4:0] result_tag;
	areg_t result_rd;
	logic [15:0] result_data;

	// three words per pattern, instruction then rd then value
	logic [15:0] pat [3*MAX_PAT];
	// scoreboard by tag, sequence number mod 32
	logic [31:0] pending;
	areg_t exp_rd [32];
	logic [15:0] exp_data [32];
	int n_pat;
	int issued;
	int completed;
	// sequence number of the oldest result not yet seen
	int oldest;
	logic full_seen;
	logic ooo_seen;
	logic [31:0] rng;

	ooo_issue_top i_dut (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_instr(in_instr),
		.full(full),
		.result_valid(result_valid),
		.result_tag(result_tag),
		.result_rd(result_rd),
		.result_data(result_data)
	);

	bind issue_queue issue_properties i_props (
		.clk(clk),
		.reset(reset),
		.disp_valid(disp_valid),
		.full(full),
		.issue_valid(issue.valid),
		.slot_ready(valid_q & {
			entry_q[3].src1.ready && entry_q[3].src2.ready,
			entry_q[2].src1.ready && entry_q[2].src2.ready,
			entry_q[1].src1.ready && entry_q[1].src2.ready,
			entry_q[0].src1.ready && entry_q[0].src2.ready
		}),
		.chosen(chosen)
	);

	function automatic logic [31:0] xorshift(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_value(input logic [15:0] actual, input logic [15:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			$display("tests failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "run aborted");
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// outputs only move at posedge, so sample them at negedge
	always @(negedge clk) begin
		if (!reset && full) begin
			full_seen = 1'b1;
		end
		if (!reset && result_valid) begin
			// each tag reports once
			check_value(16'(pending[result_tag]), 16'd1,
				$sformatf("outstanding flag of tag %0d", result_tag));
			check_value(16'(result_rd), 16'(exp_rd[result_tag]),
				$sformatf("rd of tag %0d", result_tag));
			check_value(result_data, exp_data[result_tag],
				$sformatf("data of tag %0d", result_tag));
			// younger result overtaking an older outstanding one
			if (result_tag != 5'(oldest)) begin
				ooo_seen = 1'b1;
			end
			pending[result_tag] = 1'b0;
			completed++;
			while (oldest < issued && !pending[oldest % 32]) begin
				oldest++;
			end
		end
	end

	initial begin
		int gap;
		int wait_cnt;
		int slot;
		in_valid = 1'b0;
		in_instr = '0;
		reset = 1'b1;
		pending = '0;
		issued = 0;
		completed = 0;
		oldest = 0;
		full_seen = 1'b0;
		ooo_seen = 1'b0;
		rng = 32'haeb7;
		$readmemh("testbench/issue_patterns.txt", pat);
		n_pat = 0;
		while (n_pat < MAX_PAT && !$isunknown(pat[3*n_pat])) begin
			n_pat++;
		end
		if (n_pat == 0) begin
			abort_run("no instructions could be read from the pattern file");
		end
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		// second pass wraps the tag counter, program only reads r0 before writing
		for (int p = 0; p < PASSES; p++) begin
			for (int i = 0; i < n_pat; i++) begin
				// mostly back to back so dependent bursts fill the queue
				rng = xorshift(rng);
				gap = (rng[2:0] == 3'd0) ? 2 : 0;
				repeat (gap) @(negedge clk);
				wait_cnt = 0;
				while (full) begin
					@(negedge clk);
					wait_cnt++;
					if (wait_cnt > TIMEOUT) begin
						abort_run("timeout waiting for the issue queue to leave full");
					end
				end
				slot = issued % 32;
				exp_rd[slot] = areg_t'(pat[3*i+1]);
				exp_data[slot] = pat[3*i+2];
				pending[slot] = 1'b1;
				issued++;
				in_valid = 1'b1;
				in_instr = pat[3*i];
				@(negedge clk);
				in_valid = 1'b0;
			end
		end
		// drain every outstanding tag
		wait_cnt = 0;
		while (completed != issued) begin
			@(negedge clk);
			wait_cnt++;
			if (wait_cnt > TIMEOUT) begin
				abort_run("timeout waiting for the remaining results");
			end
		end
		repeat (8) begin
			@(negedge clk);
			check_value(16'(result_valid), 16'd0, "result_valid after drain");
		end
		check_value(16'(full_seen), 16'd1, "full seen during the run");
		check_value(16'(ooo_seen), 16'd1, "out-of-order completion seen during the run");
		$display("all tests passed");
		$finish;
	end

endmodule

// ==== testbench/issue_properties.sv ====
`timescale 1ns/1ns

module issue_properties (
	input logic clk,
	input logic reset,
	input logic disp_valid,
	input logic full,
	input logic issue_valid,
	// per slot, valid with both sources ready
	input logic [3:0] slot_ready,
	input logic [1:0] chosen
);

	// producer holds off while every slot is taken
	a_no_strobe_when_full: assert property (
		@(posedge clk) disable iff (reset) !(disp_valid && full)
	) else $error("dispatch strobe while the issue queue is full");

	// select fires whenever some slot is ready and only from a ready slot
	a_issue_from_ready_slot: assert property (
		@(posedge clk) disable iff (reset)
			issue_valid == (|slot_ready) && (!issue_valid || slot_ready[chosen])
	) else $error("issue valid does not match the ready slots");

	// control outputs settle once out of reset
	a_known_outputs: assert property (
		@(posedge clk) disable iff (reset) !$isunknown({full, issue_valid})
	) else $error("full or issue valid unknown after reset");

endmodule

// ==== src/ooo_issue_top.sv ====
`timescale 1ns/1ns

module ooo_issue_top
	import decode_pkg::*;
	import issue_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic in_valid,
	input instr_u in_instr,
	output logic full,
	output logic result_valid,
	output tag_t result_tag,
	output areg_t result_rd,
	output word_t result_data
);
	logic disp_valid;
	iq_entry_t disp_entry;
	issue_t issue_q;
	// completion, also feeds back as the wake-up
	wake_t wake_q;

	dispatch_unit i_dispatch (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_instr(in_instr),
		.wake(wake_q),
		.disp_valid(disp_valid),
		.disp_entry(disp_entry)
	);

	issue_queue i_queue (
		.clk(clk),
		.reset(reset),
		.disp_valid(disp_valid),
		.disp_entry(disp_entry),
		.wake(wake_q),
		.full(full),
		.issue(issue_q)
	);

	exec_unit i_exec (
		.clk(clk),
		.reset(reset),
		.issue(issue_q),
		.wake(wake_q)
	);

	assign result_valid = wake_q.valid;
	assign result_tag = wake_q.tag;
	assign result_rd = wake_q.rd;
	assign result_data = wake_q.data;

endmodule

// ==== src/exec_unit.sv ====
`timescale 1ns/1ns
`include "iq_defs.svh"

module exec_unit
	import decode_pkg::*;
	import issue_pkg::*;
(
	input logic clk,
	input logic reset,
	input issue_t issue,
	output wake_t wake
);
	// stage one
	logic s1_valid;
	word_t s1_a;
	word_t s1_b;
	tag_t s1_tag;
	areg_t s1_rd;
	opcode_t s1_op;
	// stage two
	logic s2_valid;
	tag_t s2_tag;
	areg_t s2_rd;
	word_t s2_data;
	word_t alu;

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			s1_valid <= issue.valid;
			s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		s1_a <= issue.op1;
		// immediate ops keep only the raw field
		s1_b <= issue.ctl.use_imm ? word_t'(issue.op2[`IMM_BITS-1:0]) : issue.op2;
		s1_tag <= issue.tag;
		s1_rd <= issue.rd;
		s1_op <= issue.ctl.op;
	end

	always_comb begin
		case (s1_op)
			OP_ADD: alu = s1_a + s1_b;
			OP_SUB: alu = s1_a - s1_b;
			OP_AND: alu = s1_a & s1_b;
			OP_XOR: alu = s1_a ^ s1_b;
			// sign-extended 6-bit immediate
			OP_ADDI: alu = s1_a + {{(`WORD_BITS-`IMM_BITS){s1_b[`IMM_BITS-1]}},
				s1_b[`IMM_BITS-1:0]};
			OP_LUI: alu = s1_b << `LUI_SHIFT;
			default: alu = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		s2_tag <= s1_tag;
		s2_rd <= s1_rd;
		s2_data <= alu;
	end

	// broadcast to queue and rename table
	assign wake = '{valid: s2_valid, tag: s2_tag, rd: s2_rd, data: s2_data};

endmodule

// ==== src/issue_queue.sv ====
`timescale 1ns/1ns
`include "iq_defs.svh"

module issue_queue
	import issue_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic disp_valid,
	input iq_entry_t disp_entry,
	input wake_t wake,
	output logic full,
	output issue_t issue
);
	localparam int IDX_BITS = $clog2(`IQ_LEN);

	// candidate carried up the select tree
	typedef struct packed {
		logic ready;
		logic [IDX_BITS-1:0] idx;
		tag_t tag;
	} sel_meta_t;

	logic [`IQ_LEN-1:0] valid_q;
	iq_entry_t entry_q [`IQ_LEN];
	logic [IDX_BITS-1:0] free_idx;
	logic [IDX_BITS-1:0] chosen;
	logic write_en;

	// heap layout, node k has children 2k+1 and 2k+2, leaves at the end
	sel_meta_t node [2*`IQ_LEN-1];

	// true when a should go before b
	function automatic logic is_older(sel_meta_t a, sel_meta_t b);
		logic same_wrap;
		logic a_above;
		same_wrap = a.tag[`TAG_BITS-1] == b.tag[`TAG_BITS-1];
		a_above = a.tag[`TAG_BITS-2:0] > b.tag[`TAG_BITS-2:0];
		if (!a.ready) begin
			return 1'b0;
		end
		if (!b.ready) begin
			return 1'b1;
		end
		// same wrap: lower index older; wrap differs: higher index older
		return same_wrap ^ a_above;
	endfunction

	// lowest free slot
	always_comb begin
		free_idx = '0;
		for (int i = `IQ_LEN-1; i >= 0; i--) begin
			if (!valid_q[i]) begin
				free_idx = IDX_BITS'(i);
			end
		end
	end

	assign full = &valid_q;
	// a strobe while full is dropped
	assign write_en = disp_valid && !full;

	// leaves: slot is a candidate once both sources are ready
	for (genvar i = 0; i < `IQ_LEN; i++) begin : g_leaf
		assign node[`IQ_LEN-1+i].ready = valid_q[i]
			&& entry_q[i].src1.ready && entry_q[i].src2.ready;
		assign node[`IQ_LEN-1+i].idx = IDX_BITS'(i);
		assign node[`IQ_LEN-1+i].tag = entry_q[i].tag;
	end

	// pairwise age compares, log depth to the root
	for (genvar k = 0; k < `IQ_LEN-1; k++) begin : g_node
		assign node[k] = is_older(node[2*k+1], node[2*k+2]) ? node[2*k+1] : node[2*k+2];
	end

	assign chosen = node[0].idx;

	// root ready means some slot can go
	always_comb begin
		issue.valid = node[0].ready;
		issue.op1 = entry_q[chosen].src1.opnd.value;
		issue.op2 = entry_q[chosen].src2.opnd.value;
		issue.tag = entry_q[chosen].tag;
		issue.rd = entry_q[chosen].rd;
		issue.ctl = entry_q[chosen].ctl;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= '0;
		end else begin
			// free slot never equals chosen, both can happen at once
			if (issue.valid) begin
				valid_q[chosen] <= 1'b0;
			end
			if (write_en) begin
				valid_q[free_idx] <= 1'b1;
			end
		end
	end

	// payload, wake capture on stored sources
	always_ff @(posedge clk) begin
		for (int i = 0; i < `IQ_LEN; i++) begin
			entry_q[i].src1 <= capture_wake(entry_q[i].src1, wake);
			entry_q[i].src2 <= capture_wake(entry_q[i].src2, wake);
		end
		// dispatch already bypassed this cycle's wake
		if (write_en) begin
			entry_q[free_idx] <= disp_entry;
		end
	end

endmodule

// ==== src/dispatch_unit.sv ====
`timescale 1ns/1ns
`include "iq_defs.svh"

module dispatch_unit
	import decode_pkg::*;
	import issue_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic in_valid,
	input instr_u in_instr,
	input wake_t wake,
	output logic disp_valid,
	output iq_entry_t disp_entry
);
	// rename table, per register a value or the producer tag
	src_operand_t rename_q [`AREG_NUM];
	// age tag for the next instruction
	tag_t next_tag;
	opcode_t op;
	logic use_imm;

	// opcode sits at the same place in both views
	assign op = in_instr.r.op;
	// addi and lui read src2 from the immediate
	assign use_imm = (op == OP_ADDI) || (op == OP_LUI);
	assign disp_valid = in_valid;

	always_comb begin
		// same-cycle wake bypass on the lookup
		disp_entry.src1 = capture_wake(rename_q[in_instr.r.rs1], wake);
		// lui ignores rs1
		if (op == OP_LUI) begin
			disp_entry.src1.ready = 1'b1;
			disp_entry.src1.opnd.value = '0;
		end
		if (use_imm) begin
			// raw field only, extension happens in execute
			disp_entry.src2.ready = 1'b1;
			disp_entry.src2.opnd.value = word_t'(in_instr.i.imm);
		end else begin
			disp_entry.src2 = capture_wake(rename_q[in_instr.r.rs2], wake);
		end
		disp_entry.tag = next_tag;
		disp_entry.rd = in_instr.r.rd;
		disp_entry.ctl.op = op;
		disp_entry.ctl.use_imm = use_imm;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			next_tag <= '0;
			// all registers start ready at zero
			for (int i = 0; i < `AREG_NUM; i++) begin
				rename_q[i].ready <= 1'b1;
				rename_q[i].opnd.value <= '0;
			end
		end else begin
			// only slots still waiting on that exact tag pick up the value
			for (int i = 0; i < `AREG_NUM; i++) begin
				rename_q[i] <= capture_wake(rename_q[i], wake);
			end
			// new producer wins over a wake to the same register
			if (in_valid) begin
				rename_q[in_instr.r.rd].ready <= 1'b0;
				rename_q[in_instr.r.rd].opnd.pend.pad <= '0;
				rename_q[in_instr.r.rd].opnd.pend.tag <= next_tag;
				// wraps through 32, flipping the wrap bit every 16
				next_tag <= next_tag + 1'b1;
			end
		end
	end

endmodule

// ==== src/issue_pkg.sv ====
`include "iq_defs.svh"

package issue_pkg;
	import decode_pkg::*;

	typedef logic [`TAG_BITS-1:0] tag_t;
	typedef logic [`WORD_BITS-1:0] word_t;

	// pending sources keep the producer tag in the low bits
	typedef union packed {
		word_t value;
		struct packed {
			logic [`WORD_BITS-`TAG_BITS-1:0] pad;
			tag_t tag;
		} pend;
	} operand_u;

	typedef struct packed {
		logic ready;
		operand_u opnd;
	} src_operand_t;

	typedef struct packed {
		src_operand_t src1;
		src_operand_t src2;
		tag_t tag;
		areg_t rd;
		control_t ctl;
	} iq_entry_t;

	// completion broadcast, rd rides along for the result port
	typedef struct packed {
		logic valid;
		tag_t tag;
		areg_t rd;
		word_t data;
	} wake_t;

	typedef struct packed {
		logic valid;
		word_t op1;
		word_t op2;
		tag_t tag;
		areg_t rd;
		control_t ctl;
	} issue_t;

	// a pending source whose producer broadcasts turns ready with the data
	function automatic src_operand_t capture_wake(src_operand_t s, wake_t w);
		src_operand_t r;
		r = s;
		if (!s.ready && w.valid && s.opnd.pend.tag == w.tag) begin
			r.ready = 1'b1;
			r.opnd.value = w.data;
		end
		return r;
	endfunction

endpackage

// ==== src/decode_pkg.sv ====
`include "iq_defs.svh"

package decode_pkg;

	// architectural register index
	typedef logic [`AREG_BITS-1:0] areg_t;

	// operations of the slice
	typedef enum logic [3:0] {
		OP_ADD  = 4'h0,
		OP_SUB  = 4'h1,
		OP_AND  = 4'h2,
		OP_XOR  = 4'h3,
		OP_ADDI = 4'h4,
		OP_LUI  = 4'h5
	} opcode_t;

	// register view: opcode rd rs1 rs2, low bits unused
	typedef struct packed {
		opcode_t op;
		areg_t rd;
		areg_t rs1;
		areg_t rs2;
		logic [`WORD_BITS-4-3*`AREG_BITS-1:0] pad;
	} instr_reg_t;

	// immediate view, imm takes the place of rs2 and pad
	typedef struct packed {
		opcode_t op;
		areg_t rd;
		areg_t rs1;
		logic [`IMM_BITS-1:0] imm;
	} instr_imm_t;

	// one word, two decodings picked by the opcode
	typedef union packed {
		instr_reg_t r;
		instr_imm_t i;
	} instr_u;

	typedef struct packed {
		opcode_t op;
		logic use_imm;
	} control_t;

endpackage

// ==== include/iq_defs.svh ====
`ifndef IQ_DEFS_SVH
`define IQ_DEFS_SVH

// issue queue depth
`define IQ_LEN 4

// age tag width, top bit is the wrap bit
`define TAG_BITS 5

// datapath and instruction word width
`define WORD_BITS 16

// architectural register file size
`define AREG_NUM 8
// index width for AREG_NUM registers
`define AREG_BITS 3

// immediate field of the immediate view
`define IMM_BITS 6

// lui places the immediate this far up
`define LUI_SHIFT 10

`endif
